// File: flist.f
hdl/eboxPkg.sv
hdl/adderLogic.sv
hdl/mqShifter.sv
hdl/fastMemory.sv
hdl/dataPath.sv
hdl/stepCounter.sv
hdl/microSequencer.sv
hdl/eboxCore.sv
test/eboxCore_assert.sv
test/eboxTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the eboxCore testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module eboxTb -f flist.f

./obj_dir/VeboxTb | tee sim.log

if grep -q "^sim passed$" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

// File: test/eboxTb.sv
// Directed testbench for eboxCore at default parameters (16 memory words, 36 multiply steps)
`timescale 1ns/1ps

module eboxTb
  import eboxPkg::*;
();

  // Same values as the eboxCore defaults
  localparam int fmAddrWidth = 4;
  localparam int stepCount = 36;
  localparam int fmDepth = 1 << fmAddrWidth;
  localparam int timeoutCycles = 4 * stepCount;

  logic                   clk;
  logic                   reset;
  logic                   start;
  eboxOp                  op;
  logic [35:0]            operand;
  logic [fmAddrWidth-1:0] fmAddr;
  logic                   busy;
  logic                   done;
  logic [35:0]            resultHigh;
  logic [35:0]            resultLow;
  logic                   carry;
  logic                   fmParity;

  // Expected fast-memory contents
  logic [35:0] fmModel [0:fmDepth-1];
  logic [31:0] lfsrState;
  int          errorCount;
  int          checkCount;

  eboxCore eboxCore_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .op         (op),
    .operand    (operand),
    .fmAddr     (fmAddr),
    .busy       (busy),
    .done       (done),
    .resultHigh (resultHigh),
    .resultLow  (resultLow),
    .carry      (carry),
    .fmParity   (fmParity)
  );

  always #5 clk = ~clk;

  // Galois form, taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = {1'b0, s[31:1]};
    if (s[0]) begin
      n = n ^ 32'hD0000001;
    end
    return n;
  endfunction

  function automatic logic [35:0] randomWord();
    logic [35:0] w;
    int i;
    w = '0;
    for (i = 0; i < 36; i++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[34:0], lfsrState[0]};
    end
    return w;
  endfunction

  task automatic checkValue(input string what, input logic [71:0] actual,
                            input logic [71:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERR at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Latency counts falling edges from the start edge to the first one that sees done
  task automatic issueCommand(input eboxOp cmd, input logic [35:0] value,
                              input logic [fmAddrWidth-1:0] addr, output int latency);
    int cycles;
    @(negedge clk);
    op = cmd;
    operand = value;
    fmAddr = addr;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 1;
    while (!done && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      errorCount++;
      $display("Timeout: command %s got no done within %0d cycles", cmd.name(), cycles);
    end
    latency = cycles;
    // AR and carry take the ALU result on the edge that ends the done cycle
    @(negedge clk);
  endtask

  task automatic storeWord(input logic [35:0] value, input logic [fmAddrWidth-1:0] addr);
    int lat;
    issueCommand(opWriteWord, value, addr, lat);
    fmModel[addr] = value;
    checkValue("store latency", 72'(lat), 72'(2));
  endtask

  task automatic writeAndReadBack(input eboxOp cmd, input logic [35:0] value,
                                  input logic [fmAddrWidth-1:0] addr);
    int lat;
    issueCommand(cmd, value, addr, lat);
    checkValue("write latency", 72'(lat), 72'(2));
    checkValue("AR after write", 72'(resultHigh), 72'(value));
    // Left half is bits 0..17, the upper end of a [35:0] vector
    if (cmd != opWriteRight) begin
      fmModel[addr][35:18] = value[35:18];
    end
    if (cmd != opWriteLeft) begin
      fmModel[addr][17:0] = value[17:0];
    end
    issueCommand(opOr, 36'h0, addr, lat);
    checkValue("read latency", 72'(lat), 72'(2));
    checkValue("read word", 72'(resultHigh), 72'(fmModel[addr]));
    checkValue("carry after OR", 72'(carry), 72'(0));
    checkValue("fmParity", 72'(fmParity), 72'(^fmModel[addr]));
  endtask

  task automatic checkAlu(input eboxOp cmd, input logic [35:0] a, input logic [35:0] b,
                          input logic [fmAddrWidth-1:0] addr);
    logic [36:0] wide;
    logic [35:0] expWord;
    logic [35:0] mqBefore;
    logic        expCarry;
    int          lat;
    storeWord(b, addr);
    mqBefore = resultLow;
    issueCommand(cmd, a, addr, lat);
    expCarry = 1'b0;
    case (cmd)
      opAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        expWord = wide[35:0];
        expCarry = wide[36];
      end
      opSub: begin
        // Carry set means no borrow
        expWord = a - b;
        expCarry = (a >= b);
      end
      opAnd: expWord = a & b;
      opOr:  expWord = a | b;
      default: expWord = a ^ b;
    endcase
    checkValue("ALU latency", 72'(lat), 72'(2));
    checkValue({cmd.name(), " result"}, 72'(resultHigh), 72'(expWord));
    checkValue({cmd.name(), " carry"}, 72'(carry), 72'(expCarry));
    checkValue("MQ held", 72'(resultLow), 72'(mqBefore));
  endtask

  task automatic checkMul(input logic [35:0] a, input logic [35:0] b,
                          input logic [fmAddrWidth-1:0] addr);
    logic [71:0] prod;
    int          lat;
    storeWord(b, addr);
    issueCommand(opMul, a, addr, lat);
    prod = {36'h0, a} * {36'h0, b};
    checkValue("multiply latency", 72'(lat), 72'(stepCount + 2));
    checkValue("product high", 72'(resultHigh), 72'(prod[71:36]));
    checkValue("product low", 72'(resultLow), 72'(prod[35:0]));
  endtask

  task automatic testReset();
    checkValue("busy after reset", 72'(busy), 72'(0));
    checkValue("done after reset", 72'(done), 72'(0));
    checkValue("AR after reset", 72'(resultHigh), 72'(0));
    checkValue("MQ after reset", 72'(resultLow), 72'(0));
    checkValue("carry after reset", 72'(carry), 72'(0));
  endtask

  task automatic testWrites();
    int i;
    // Whole words everywhere first, so no location is left undefined
    for (i = 0; i < fmDepth; i++) begin
      writeAndReadBack(opWriteWord, randomWord(), fmAddrWidth'(i));
    end
    writeAndReadBack(opWriteLeft, randomWord(), fmAddrWidth'(3));
    writeAndReadBack(opWriteRight, randomWord(), fmAddrWidth'(3));
    writeAndReadBack(opWriteLeft, 36'hFFFFFFFFF, fmAddrWidth'(9));
    writeAndReadBack(opWriteRight, 36'h000000000, fmAddrWidth'(14));
    writeAndReadBack(opWriteRight, randomWord(), fmAddrWidth'(15));
    writeAndReadBack(opWriteWord, 36'h800000001, fmAddrWidth'(0));
  endtask

  task automatic testAddSub();
    logic [35:0] edgeValues [0:2];
    int i;
    int j;
    edgeValues[0] = 36'hFFFFFFFFF;
    edgeValues[1] = 36'h000000000;
    edgeValues[2] = 36'h800000000;
    for (i = 0; i < 3; i++) begin
      for (j = 0; j < 3; j++) begin
        checkAlu(opAdd, edgeValues[i], edgeValues[j], fmAddrWidth'(4));
        checkAlu(opSub, edgeValues[i], edgeValues[j], fmAddrWidth'(5));
      end
    end
    for (i = 0; i < 8; i++) begin
      checkAlu(opAdd, randomWord(), randomWord(), fmAddrWidth'(6));
      checkAlu(opSub, randomWord(), randomWord(), fmAddrWidth'(6));
    end
  endtask

  task automatic testBoolean();
    int i;
    for (i = 0; i < 8; i++) begin
      checkAlu(opAnd, randomWord(), randomWord(), fmAddrWidth'(i));
      checkAlu(opOr, randomWord(), randomWord(), fmAddrWidth'(i + 1));
      checkAlu(opXor, randomWord(), randomWord(), fmAddrWidth'(i + 2));
    end
  endtask

  task automatic testMultiply();
    int i;
    for (i = 0; i < 6; i++) begin
      checkMul(randomWord(), randomWord(), fmAddrWidth'(10));
    end
    checkMul(36'hFFFFFFFFF, 36'hFFFFFFFFF, fmAddrWidth'(11));
    checkMul(36'h000000000, randomWord(), fmAddrWidth'(12));
  endtask

  task automatic testIgnoredStart();
    logic [35:0] a;
    logic [35:0] b;
    logic [71:0] prod;
    int          cycles;
    int          doneCount;
    int          doneAt;
    a = randomWord();
    b = randomWord();
    storeWord(b, fmAddrWidth'(7));
    @(negedge clk);
    op = opMul;
    operand = a;
    fmAddr = fmAddrWidth'(7);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 1;
    doneCount = 0;
    doneAt = 0;
    // Fixed window reaching a few cycles past the expected done
    while (cycles <= stepCount + 6) begin
      if (done) begin
        doneCount++;
        doneAt = cycles;
      end
      // Second start with another command in the middle of the multiply
      start = (cycles == 5);
      op = (cycles == 5) ? opAdd : opMul;
      @(negedge clk);
      cycles++;
    end
    prod = {36'h0, a} * {36'h0, b};
    checkValue("done pulses", 72'(doneCount), 72'(1));
    checkValue("done cycle", 72'(doneAt), 72'(stepCount + 2));
    checkValue("busy after multiply", 72'(busy), 72'(0));
    checkValue("product high", 72'(resultHigh), 72'(prod[71:36]));
    checkValue("product low", 72'(resultLow), 72'(prod[35:0]));
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    op = opWriteWord;
    operand = '0;
    fmAddr = '0;
    lfsrState = 32'h11d25f1e;
    errorCount = 0;
    checkCount = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    testReset();
    testWrites();
    testAddSub();
    testBoolean();
    testMultiply();
    testIgnoredStart();
    repeat (2) @(negedge clk);
    $display("Finished with %0d checks and %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: test/eboxCore_assert.sv
// Bound into microSequencer; the write state code follows its state list order (idle, load, write)
`timescale 1ns/1ps

module eboxCore_assert (
  input logic       clk,
  input logic       reset,
  input logic       busy,
  input logic       done,
  input logic       writeLeft,
  input logic       writeRight,
  input logic [2:0] state
);

  localparam logic [2:0] writeState = 3'd2;

  doneOnePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // Sequencer returns to idle right after done
  busyAfterDone: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
    else $error("busy still high after done");

  writeOnlyInWrite: assert property (@(posedge clk) disable iff (reset)
    (writeLeft || writeRight) |-> (state == writeState))
    else $error("fast-memory write enable outside the write state");

endmodule

bind microSequencer eboxCore_assert eboxCore_assert_i (
  .clk        (clk),
  .reset      (reset),
  .busy       (busy),
  .done       (done),
  .writeLeft  (writeLeft),
  .writeRight (writeRight),
  .state      (state)
);

// File: hdl/eboxCore.sv
// Top level; fmAddr and operand must stay stable from start until done
`timescale 1ns/1ps

module eboxCore
  import eboxPkg::*;
#(
  parameter int fmAddrWidth = 4,
  parameter int stepCount = 36
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  eboxOp                  op,
  input  eboxWord                operand,
  input  logic [fmAddrWidth-1:0] fmAddr,
  output logic                   busy,
  output logic                   done,
  output eboxWord                resultHigh,
  output eboxWord                resultLow,
  output logic                   carry,
  output logic                   fmParity
);

  arSource arSel;
  mqMode   mqSel;
  aluFunc  aluSel;
  logic    brLoad;
  logic    carryLoad;
  logic    mqLsb;
  logic    writeLeft;
  logic    writeRight;
  logic    countStart;
  logic    countStep;
  logic    countZero;
  eboxWord fmData;

  microSequencer microSequencer_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .op         (op),
    .busy       (busy),
    .done       (done),
    .arSel      (arSel),
    .brLoad     (brLoad),
    .mqSel      (mqSel),
    .aluSel     (aluSel),
    .carryLoad  (carryLoad),
    .mqLsb      (mqLsb),
    .writeLeft  (writeLeft),
    .writeRight (writeRight),
    .countStart (countStart),
    .countStep  (countStep),
    .countZero  (countZero)
  );

  stepCounter #(
    .stepCount (stepCount)
  ) stepCounter_i (
    .clk        (clk),
    .reset      (reset),
    .countStart (countStart),
    .countStep  (countStep),
    .countZero  (countZero)
  );

  dataPath dataPath_i (
    .clk       (clk),
    .reset     (reset),
    .operand   (operand),
    .fmData    (fmData),
    .arSel     (arSel),
    .brLoad    (brLoad),
    .mqSel     (mqSel),
    .aluSel    (aluSel),
    .carryLoad (carryLoad),
    .ar        (resultHigh),
    .mq        (resultLow),
    .mqLsb     (mqLsb),
    .carry     (carry)
  );

  // Memory is written from AR
  fastMemory #(
    .fmAddrWidth (fmAddrWidth)
  ) fastMemory_i (
    .clk        (clk),
    .addr       (fmAddr),
    .writeData  (resultHigh),
    .writeLeft  (writeLeft),
    .writeRight (writeRight),
    .readData   (fmData),
    .parity     (fmParity)
  );

endmodule

// File: hdl/microSequencer.sv
// Command FSM; start is taken only in idle, and op must not change meaning until done
`timescale 1ns/1ps

module microSequencer
  import eboxPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  eboxOp   op,
  output logic    busy,
  output logic    done,
  output arSource arSel,
  output logic    brLoad,
  output mqMode   mqSel,
  output aluFunc  aluSel,
  output logic    carryLoad,
  input  logic    mqLsb,
  output logic    writeLeft,
  output logic    writeRight,
  output logic    countStart,
  output logic    countStep,
  input  logic    countZero
);

  // Every command spends one cycle in load before its own state
  typedef enum logic [2:0] {
    stIdle,
    stLoad,
    stWrite,
    stAlu,
    stMulStep,
    stFinish
  } seqState;

  seqState state;
  seqState stateNext;
  eboxOp   opReg;
  aluFunc  opFunc;
  logic    isMul;
  logic    isWrite;

  assign isMul = (opReg == opMul);
  assign isWrite = (opReg == opWriteWord) || (opReg == opWriteLeft) ||
                   (opReg == opWriteRight);

  always_comb begin
    case (opReg)
      opAdd:   opFunc = aluAdd;
      opSub:   opFunc = aluSub;
      opAnd:   opFunc = aluAnd;
      opOr:    opFunc = aluOr;
      opXor:   opFunc = aluXor;
      default: opFunc = aluPassA;
    endcase
  end

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (start) begin
          stateNext = stLoad;
        end
      end
      stLoad: begin
        if (isMul) begin
          stateNext = stMulStep;
        end else if (isWrite) begin
          stateNext = stWrite;
        end else begin
          stateNext = stAlu;
        end
      end
      stMulStep: begin
        // Count reached zero on the last step
        if (countZero) begin
          stateNext = stFinish;
        end
      end
      default: begin
        stateNext = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
      opReg <= opWriteWord;
    end else begin
      state <= stateNext;
      if (state == stIdle && start) begin
        opReg <= op;
      end
    end
  end

  // Counter loads on the accepted start and takes its first step in load,
  // so the final multiply step is the one that sees countZero
  assign countStart = (state == stIdle) && start;
  assign busy = (state != stIdle);

  always_comb begin
    arSel = arHold;
    brLoad = 1'b0;
    mqSel = mqHold;
    aluSel = aluPassA;
    carryLoad = 1'b0;
    writeLeft = 1'b0;
    writeRight = 1'b0;
    countStep = 1'b0;
    done = 1'b0;
    case (state)
      stLoad: begin
        if (isMul) begin
          brLoad = 1'b1;
          mqSel = mqLoad;
          countStep = 1'b1;
        end else begin
          arSel = arOperand;
          brLoad = !isWrite;
        end
      end
      stWrite: begin
        writeLeft = (opReg == opWriteWord) || (opReg == opWriteLeft);
        writeRight = (opReg == opWriteWord) || (opReg == opWriteRight);
        done = 1'b1;
      end
      stAlu: begin
        arSel = arAdder;
        aluSel = opFunc;
        carryLoad = 1'b1;
        done = 1'b1;
      end
      stMulStep: begin
        // Add the multiplicand only when the multiplier bit is set
        arSel = arAdderShift;
        mqSel = mqShiftRight;
        aluSel = mqLsb ? aluAdd : aluPassA;
        countStep = !countZero;
      end
      stFinish: begin
        done = 1'b1;
      end
      default: begin
        done = 1'b0;
      end
    endcase
  end

endmodule

// File: hdl/stepCounter.sv
// Down-counter for the multiply loop; it stops at zero and countZero is high after reset
`timescale 1ns/1ps

module stepCounter #(
  parameter int stepCount = 36
) (
  input  logic clk,
  input  logic reset,
  input  logic countStart,
  input  logic countStep,
  output logic countZero
);

  localparam int countWidth = $clog2(stepCount + 1);

  logic [countWidth-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (countStart) begin
      count <= countWidth'(stepCount);
    end else if (countStep && !countZero) begin
      count <= count - countWidth'(1);
    end
  end

  assign countZero = (count == '0);

endmodule

// File: hdl/dataPath.sv
// AR, BR, MQ and carry registers; an MQ load also clears AR to start a multiply
`timescale 1ns/1ps

module dataPath
  import eboxPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  eboxWord operand,
  input  eboxWord fmData,
  input  arSource arSel,
  input  logic    brLoad,
  input  mqMode   mqSel,
  input  aluFunc  aluSel,
  input  logic    carryLoad,
  output eboxWord ar,
  output eboxWord mq,
  output logic    mqLsb,
  output logic    carry
);

  eboxWord br;
  eboxWord arNext;
  eboxWord adderSum;
  logic    adderCarry;

  // Adder always sees AR on A and BR on B
  adderLogic adderLogic_i (
    .a        (ar),
    .b        (br),
    .func     (aluSel),
    .sum      (adderSum),
    .carryOut (adderCarry)
  );

  // Low bit of the sum shifts into MQ during a multiply step
  mqShifter mqShifter_i (
    .clk       (clk),
    .reset     (reset),
    .mode      (mqSel),
    .loadValue (operand),
    .fillBit   (adderSum[wordWidth-1]),
    .q         (mq)
  );

  assign mqLsb = mq[wordWidth-1];

  // AR source mux
  always_comb begin
    arNext = ar;
    unique case (arSel)
      arHold: begin
        arNext = ar;
      end
      arOperand: begin
        arNext = operand;
      end
      arAdder: begin
        arNext = adderSum;
      end
      arAdderShift: begin
        // Sum moves right one place, carry comes in at bit 0
        arNext = {adderCarry, adderSum[0:wordWidth-2]};
      end
    endcase

    // Partial product starts at zero when the multiplier goes into MQ
    if (mqSel == mqLoad) begin
      arNext = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ar <= '0;
      br <= '0;
      carry <= 1'b0;
    end else begin
      ar <= arNext;
      if (brLoad) begin
        br <= fmData;
      end
      if (carryLoad) begin
        carry <= adderCarry;
      end
    end
  end

endmodule

// File: hdl/fastMemory.sv
// Fast memory with combinational read and per-half write enables; contents are not reset
`timescale 1ns/1ps

module fastMemory
  import eboxPkg::*;
#(
  parameter int fmAddrWidth = 4
) (
  input  logic                   clk,
  input  logic [fmAddrWidth-1:0] addr,
  input  eboxWord                writeData,
  input  logic                   writeLeft,
  input  logic                   writeRight,
  output eboxWord                readData,
  output logic                   parity
);

  localparam int depth = 1 << fmAddrWidth;
  localparam int halfWidth = wordWidth / 2;

  eboxWord mem [0:depth-1];

  // Left half is bits 0..17, right half is bits 18..35
  always_ff @(posedge clk) begin
    if (writeLeft) begin
      mem[addr][0:halfWidth-1] <= writeData[0:halfWidth-1];
    end
    if (writeRight) begin
      mem[addr][halfWidth:wordWidth-1] <= writeData[halfWidth:wordWidth-1];
    end
  end

  assign readData = mem[addr];

  // Word parity straight off the read port
  assign parity = ^readData;

endmodule

// File: hdl/mqShifter.sv
// MQ shift register; a right shift moves bits toward bit 35 and brings fillBit into bit 0
`timescale 1ns/1ps

module mqShifter
  import eboxPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  mqMode   mode,
  input  eboxWord loadValue,
  input  logic    fillBit,
  output eboxWord q
);

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else begin
      unique case (mode)
        mqHold: begin
          q <= q;
        end
        mqLoad: begin
          q <= loadValue;
        end
        mqShiftRight: begin
          // Bit 35 drops out, it was consumed by the multiply step
          q <= {fillBit, q[0:wordWidth-2]};
        end
        mqClear: begin
          q <= '0;
        end
      endcase
    end
  end

endmodule

// File: hdl/adderLogic.sv
// Purely combinational; carry out is the carry from bit 0, and zero for pass and boolean functions
`timescale 1ns/1ps

module adderLogic
  import eboxPkg::*;
(
  input  eboxWord    a,
  input  eboxWord    b,
  input  aluFunc     func,
  output eboxWord    sum,
  output logic       carryOut
);

  // One extra bit on the left holds the carry out of bit 0
  logic [0:wordWidth] wide;
  logic [0:wordWidth] wideA;
  logic [0:wordWidth] wideB;
  logic [0:wordWidth] wideOne;

  assign wideA = {1'b0, a};
  assign wideB = {1'b0, b};
  assign wideOne = {{wordWidth{1'b0}}, 1'b1};

  // Same function set the 10181 slices give us, but over the whole word at once
  always_comb begin
    wide = wideA;
    case (func)
      aluPassA: begin
        wide = wideA;
      end
      aluAdd: begin
        wide = wideA + wideB;
      end
      aluSub: begin
        // Two's complement subtract, carry set means no borrow
        wide = wideA + {1'b0, ~b} + wideOne;
      end
      aluAnd: begin
        wide = {1'b0, a & b};
      end
      aluOr: begin
        wide = {1'b0, a | b};
      end
      aluXor: begin
        wide = {1'b0, a ^ b};
      end
      default: begin
        wide = wideA;
      end
    endcase
  end

  assign carryOut = wide[0];
  assign sum = wide[1:wordWidth];

endmodule

// File: hdl/eboxPkg.sv
// Word, command and control encodings for the data path; bit 0 is the most significant bit
package eboxPkg;

  // Every data module carries this one word size
  localparam int wordWidth = 36;

  typedef logic [0:wordWidth-1] eboxWord;

  // Command codes, nine of them, so four bits
  typedef enum logic [3:0] {
    opWriteWord  = 4'd0,
    opWriteLeft  = 4'd1,
    opWriteRight = 4'd2,
    opAdd        = 4'd3,
    opSub        = 4'd4,
    opAnd        = 4'd5,
    opOr         = 4'd6,
    opXor        = 4'd7,
    opMul        = 4'd8
  } eboxOp;

  typedef enum logic [2:0] {
    aluPassA = 3'd0,
    aluAdd   = 3'd1,
    aluSub   = 3'd2,
    aluAnd   = 3'd3,
    aluOr    = 3'd4,
    aluXor   = 3'd5
  } aluFunc;

  typedef enum logic [1:0] {
    arHold       = 2'd0,
    arOperand    = 2'd1,
    arAdder      = 2'd2,
    arAdderShift = 2'd3
  } arSource;

  typedef enum logic [1:0] {
    mqHold       = 2'd0,
    mqLoad       = 2'd1,
    mqShiftRight = 2'd2,
    mqClear      = 2'd3
  } mqMode;

endpackage
